//--- src.f
common/bridge_pkg.sv
jtag_fifo/jtag_shifter.sv
jtag_fifo/jtag_fifo_slave.sv
logic/frame_cfg_slave.sv
logic/resp_merge.sv
logic/cmd_bridge_top.sv
sim/resp_checker.sv
sim/tb_top.sv

//--- Makefile
TOOL    ?= verilator
FLAGS   ?= --binary --timing --assert -j 0
TOP     ?= tb_top
FILES   ?= src.f
OBJ_DIR ?= obj_dir
LOG     ?= sim.log

.PHONY: help test clean

help:
	@echo "make test   build and run the simulation, fail if the log reports failure"
	@echo "make clean  remove build output and log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILES) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q ">>> PASS" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim/tb_top.sv
`timescale 1ns/10ps

module tb_top import bridge_pkg::*; ();

	logic         external_clk;
	logic         arst_n;
	cmd_t         cmd;
	bus_rsp_t     rsp;
	frame_cfg_t   frame;
	logic         tck, tms, tdi;

	logic [159:0] test_name;
	logic [15:0]  lfsr;
	id_t          next_id;
	id_t          sent_id;
	int           checks, errors, bits_seen;
	int           tb_checks, tb_errors, timeouts;
	int           polls;
	data_t        rd, w0, w1, w2;

	cmd_bridge_top u_dut (
		.external_clk (external_clk),
		.arst_n       (arst_n),
		.cmd          (cmd),
		.rsp          (rsp),
		.frame        (frame),
		.tck          (tck),
		.tms          (tms),
		.tdi          (tdi)
	);

	resp_checker u_chk (
		.external_clk (external_clk),
		.arst_n       (arst_n),
		.cmd          (cmd),
		.rsp          (rsp),
		.frame        (frame),
		.tck          (tck),
		.tms          (tms),
		.tdi          (tdi),
		.test_name    (test_name),
		.checks       (checks),
		.errors       (errors),
		.bits_seen    (bits_seen)
	);

	initial begin
		external_clk = 1'b0;
		forever #10 external_clk = ~external_clk;
	end

	////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////
	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic rand_word(output data_t w);
		w = '0;
		for (int i = 0; i < 32; i++) begin
			lfsr = lfsr_next(lfsr);
			w    = {w[30:0], lfsr[0]};
		end
	endtask

	// one-cycle strobe, called 2 ns after an edge
	task automatic send(input logic wr, input addr_t a, input data_t d);
		cmd     = '{valid: 1'b1, write: wr, id: next_id, addr: a, data: d};
		sent_id = next_id;
		next_id = next_id + 1'b1;
		@(posedge external_clk);
		#2;
		cmd.valid = 1'b0;
	endtask

	// waits for the response to the last command sent
	task automatic wait_rsp(output data_t rdata);
		int n;
		n     = 0;
		rdata = '0;
		while (n < 10) begin
			@(posedge external_clk);
			if (rsp.valid && rsp.id == sent_id) begin
				rdata = rsp.rdata;
				break;
			end
			n++;
		end
		#2;
		if (n == 10) begin
			timeouts++;
			$display("%0s: timed out waiting for response id %0d", test_name, sent_id);
		end
	endtask

	task automatic read_reg(input addr_t a, output data_t rdata);
		send(1'b0, a, '0);
		wait_rsp(rdata);
	endtask

	task automatic write_reg(input addr_t a, input data_t d);
		data_t dummy;
		send(1'b1, a, d);
		wait_rsp(dummy);
	endtask

	task automatic check_word(input string what, input data_t exp, input data_t act);
		tb_checks++;
		if (exp !== act) begin
			tb_errors++;
			$display("error %0s %0s expected %h actual %h", test_name, what, exp, act);
		end
	endtask

	////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////
	initial begin
		cmd       = '0;
		arst_n    = 1'b0;
		lfsr      = 16'd43;
		next_id   = '0;
		sent_id   = '0;
		tb_checks = 0;
		tb_errors = 0;
		timeouts  = 0;
		test_name = "reset";
		repeat (8) @(posedge external_clk);
		#2;
		arst_n = 1'b1;
		@(posedge external_clk);
		#2;

		test_name = "reset_values";
		read_reg(ADDR_JTAG_STATUS, rd);
		read_reg(ADDR_FRAME_BASE, rd);
		read_reg(ADDR_FRAME_WORDS, rd);
		read_reg(ADDR_FRAME_EN, rd);

		// back to back, two commands in flight
		test_name = "fifo_fill";
		for (int i = 0; i < 4; i++) begin
			rand_word(w0);
			send(1'b1, ADDR_JTAG_DATA, w0);
		end
		send(1'b0, ADDR_JTAG_STATUS, '0);
		for (int i = 0; i < 4; i++) begin
			rand_word(w0);
			send(1'b1, ADDR_JTAG_DATA, w0);
		end
		send(1'b0, ADDR_JTAG_STATUS, '0);
		rand_word(w0);
		send(1'b1, ADDR_JTAG_DATA, w0);   // ninth push overflows
		send(1'b0, ADDR_JTAG_STATUS, '0);
		wait_rsp(rd);

		test_name = "fifo_clear";
		write_reg(ADDR_JTAG_STATUS, 32'h1);
		read_reg(ADDR_JTAG_STATUS, rd);

		test_name = "jtag_shift";
		rand_word(w0);
		write_reg(ADDR_JTAG_DATA, w0);
		rand_word(w1);
		write_reg(ADDR_JTAG_DATA, w1);
		write_reg(ADDR_JTAG_STATUS, 32'h2);
		polls = 0;
		rd    = 32'h0001_0000;
		while (polls < 100 && (rd[STAT_BUSY] || !rd[STAT_EMPTY])) begin
			read_reg(ADDR_JTAG_STATUS, rd);
			polls++;
		end
		if (rd[STAT_BUSY] || !rd[STAT_EMPTY]) begin
			timeouts++;
			$display("%0s: shifter still busy after %0d status polls", test_name, polls);
		end
		check_word("shifted bits", 32'd64, bits_seen);

		test_name = "frame_cfg";
		rand_word(w0);
		w1 = 64 * 24 * 16 / 32;
		rand_word(w2);
		w2 = w2 | 32'h1;
		write_reg(ADDR_FRAME_BASE, w0);
		write_reg(ADDR_FRAME_WORDS, w1);
		write_reg(ADDR_FRAME_EN, w2);
		read_reg(ADDR_FRAME_BASE, rd);
		check_word("base readback", w0, rd);
		read_reg(ADDR_FRAME_WORDS, rd);
		check_word("words readback", w1, rd);
		read_reg(ADDR_FRAME_EN, rd);
		check_word("enable readback", 32'h1, rd);
		check_word("frame base", w0, frame.base);
		check_word("frame words", w1, frame.words);
		check_word("frame enable", 32'h1, {31'b0, frame.enable});

		test_name = "unmapped";
		read_reg(32'h1000_0010, rd);
		write_reg(32'h1000_0010, 32'hffff_ffff);
		write_reg(32'h7000_0015, 32'h0);
		write_reg(32'h1000_0001, 32'h1);   // would clear if decoded
		read_reg(32'h0000_0000, rd);
		read_reg(ADDR_FRAME_BASE, rd);
		check_word("base kept", w0, rd);
		read_reg(ADDR_JTAG_STATUS, rd);

		$display("checks %0d, errors %0d, timeouts %0d",
			checks + tb_checks, errors + tb_errors, timeouts);
		if (errors + tb_errors + timeouts == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

//--- sim/resp_checker.sv
`timescale 1ns/10ps

module resp_checker import bridge_pkg::*; (
	input  logic         external_clk,
	input  logic         arst_n,
	input  cmd_t         cmd,
	input  bus_rsp_t     rsp,
	input  frame_cfg_t   frame,
	input  logic         tck,
	input  logic         tms,
	input  logic         tdi,
	input  logic [159:0] test_name,
	output int           checks,
	output int           errors,
	output int           bits_seen
);

	typedef struct {
		bus_rsp_t rsp;
		int       stamp;   // edge on which the command was taken
	} exp_t;

	exp_t  exp_q[$];
	data_t fifo_q[$];      // words held by the model fifo
	data_t popped_q[$];    // words handed to the shifter, in order
	logic  m_shift_en;
	int    m_busy;         // shifter cycles still to run
	data_t m_base;
	data_t m_words;
	logic  m_en;
	int    edge_cnt;

	int rsp_checks = 0;
	int rsp_errors = 0;
	int bit_cnt = 0;
	int bit_errors = 0;

	assign checks    = rsp_checks + bit_cnt;
	assign errors    = rsp_errors + bit_errors;
	assign bits_seen = bit_cnt;

	////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////
	function automatic bus_rsp_t ref_rsp(input cmd_t c);
		bus_rsp_t r;
		data_t    stat;
		logic     full;
		full = fifo_q.size() == FIFO_DEPTH;
		stat = '0;
		stat[STAT_CNT_LSB +: 4] = 4'(fifo_q.size());
		stat[STAT_SHIFT_EN]     = m_shift_en;
		stat[STAT_EMPTY]        = fifo_q.size() == 0;
		stat[STAT_FULL]         = full;
		stat[STAT_BUSY]         = m_busy != 0;
		r = '{valid: 1'b1, id: c.id, resp: RESP_OKAY, rdata: '0};
		case (c.addr)
			ADDR_JTAG_STATUS: if (!c.write) r.rdata = stat;
			ADDR_JTAG_DATA:   if (c.write && full) r.resp = RESP_SLVERR;
			ADDR_FRAME_BASE:  if (!c.write) r.rdata = m_base;
			ADDR_FRAME_WORDS: if (!c.write) r.rdata = m_words;
			ADDR_FRAME_EN:    if (!c.write) r.rdata = {31'b0, m_en};
			default:          r.resp = RESP_SLVERR;   // nobody owns it
		endcase
		return r;
	endfunction

	// one clock edge of register effects plus the shifter
	task automatic step_model(input cmd_t c);
		logic wr;
		logic stat_wr;
		logic clear;
		logic push;
		logic pop;
		wr      = c.valid && c.write;
		stat_wr = wr && c.addr == ADDR_JTAG_STATUS;
		clear   = stat_wr && c.data[CTRL_CLEAR];
		push    = wr && c.addr == ADDR_JTAG_DATA && fifo_q.size() < FIFO_DEPTH;
		pop     = m_shift_en && fifo_q.size() != 0 && m_busy == 0 && !clear;
		if (pop) begin
			popped_q.push_back(fifo_q.pop_front());
			m_busy = 64;   // 32 bits, low and high phase each
		end else if (m_busy != 0) begin
			m_busy--;
		end
		if (clear)
			fifo_q.delete();
		else if (push)
			fifo_q.push_back(c.data);
		if (stat_wr)
			m_shift_en = c.data[CTRL_SHIFT_EN];
		if (wr && c.addr == ADDR_FRAME_BASE)
			m_base = c.data;
		if (wr && c.addr == ADDR_FRAME_WORDS)
			m_words = c.data;
		if (wr && c.addr == ADDR_FRAME_EN)
			m_en = c.data[0];
	endtask

	////////////////////////////////////////////////////////////
	// compare
	////////////////////////////////////////////////////////////
	always @(posedge external_clk) begin
		exp_t e;
		if (!arst_n) begin
			exp_q.delete();
			fifo_q.delete();
			m_shift_en = 1'b0;
			m_busy     = 0;
			m_base     = '0;
			m_words    = '0;
			m_en       = 1'b0;
			edge_cnt   = 0;
		end else begin
			edge_cnt++;
			rsp_checks++;
			if (frame !== frame_cfg_t'{base: m_base, words: m_words, enable: m_en}) begin
				rsp_errors++;
				$display("error %0s frame expected %h/%h/%b actual %h/%h/%b", test_name,
					m_base, m_words, m_en, frame.base, frame.words, frame.enable);
			end
			if (rsp.valid) begin
				if (exp_q.size() == 0) begin
					rsp_errors++;
					$display("%0s: response came without a command", test_name);
				end else begin
					e = exp_q.pop_front();
					rsp_checks++;
					if (edge_cnt - e.stamp != 2) begin
						rsp_errors++;
						$display("%0s: response latency was %0d cycles instead of 2",
							test_name, edge_cnt - e.stamp);
					end
					if (rsp !== e.rsp) begin
						rsp_errors++;
						$display("error %0s id/resp/rdata expected %0d/%0d/%h actual %0d/%0d/%h",
							test_name, e.rsp.id, e.rsp.resp, e.rsp.rdata,
							rsp.id, rsp.resp, rsp.rdata);
					end
				end
			end
			while (exp_q.size() != 0 && edge_cnt - exp_q[0].stamp >= 2) begin
				e = exp_q.pop_front();
				rsp_errors++;
				$display("%0s: no response for command id %0d", test_name, e.rsp.id);
			end
			if (cmd.valid)
				exp_q.push_back(exp_t'{rsp: ref_rsp(cmd), stamp: edge_cnt});
			step_model(cmd);
		end
	end

	// serial stream, lsb first, tms on the last bit
	always @(posedge tck) begin
		data_t w;
		int    idx;
		idx = bit_cnt % 32;
		if (bit_cnt / 32 >= popped_q.size()) begin
			bit_errors++;
			$display("%0s: tck pulse without a word taken from the fifo", test_name);
		end else begin
			w = popped_q[bit_cnt / 32];
			if (tdi !== w[idx] || tms !== (idx == 31)) begin
				bit_errors++;
				$display("error %0s tdi/tms bit %0d expected %b/%b actual %b/%b",
					test_name, idx, w[idx], idx == 31, tdi, tms);
			end
		end
		bit_cnt++;
	end

endmodule

//--- logic/cmd_bridge_top.sv
`timescale 1ns/10ps

module cmd_bridge_top import bridge_pkg::*; (
	input  logic       external_clk,
	input  logic       arst_n,
	input  cmd_t       cmd,
	output bus_rsp_t   rsp,
	output frame_cfg_t frame,
	output logic       tck,
	output logic       tms,
	output logic       tdi
);

	slv_rsp_t jtag_rsp;
	slv_rsp_t frm_rsp;

	////////////////////////////////////////////////////////////
	// slaves, cmd broadcast to both
	////////////////////////////////////////////////////////////
	jtag_fifo_slave u_jtag (
		.external_clk (external_clk),
		.arst_n       (arst_n),
		.cmd          (cmd),
		.rsp          (jtag_rsp),
		.tck          (tck),
		.tms          (tms),
		.tdi          (tdi)
	);

	frame_cfg_slave u_frame (
		.external_clk (external_clk),
		.arst_n       (arst_n),
		.cmd          (cmd),
		.rsp          (frm_rsp),
		.frame        (frame)
	);

	resp_merge u_merge (
		.external_clk (external_clk),
		.arst_n       (arst_n),
		.jtag         (jtag_rsp),
		.frm          (frm_rsp),
		.rsp          (rsp)
	);

endmodule

//--- logic/resp_merge.sv
`timescale 1ns/10ps

module resp_merge import bridge_pkg::*; (
	input  logic     external_clk,
	input  logic     arst_n,
	input  slv_rsp_t jtag,
	input  slv_rsp_t frm,
	output bus_rsp_t rsp
);

	logic  rsp_vld;
	id_t   rsp_id;
	resp_t rsp_code;
	data_t rsp_data;

	always_ff @(posedge external_clk or negedge arst_n) begin
		if (!arst_n)
			rsp_vld <= 1'b0;
		else
			rsp_vld <= jtag.valid | frm.valid;
	end

	always_ff @(posedge external_clk) begin
		if (jtag.hit) begin
			rsp_id   <= jtag.id;
			rsp_code <= jtag.resp;
			rsp_data <= jtag.rdata;
		end else if (frm.hit) begin
			rsp_id   <= frm.id;
			rsp_code <= frm.resp;
			rsp_data <= frm.rdata;
		end else begin   // nobody owns it
			rsp_id   <= jtag.id;
			rsp_code <= RESP_SLVERR;
			rsp_data <= '0;
		end
	end

	assign rsp = '{valid: rsp_vld, id: rsp_id, resp: rsp_code, rdata: rsp_data};

	// address ranges of the two slaves are disjoint
	a_one_hit: assert property (@(posedge external_clk) disable iff (!arst_n)
		!(jtag.hit && frm.hit));

endmodule

//--- logic/frame_cfg_slave.sv
`timescale 1ns/10ps

module frame_cfg_slave import bridge_pkg::*; (
	input  logic       external_clk,
	input  logic       arst_n,
	input  cmd_t       cmd,
	output slv_rsp_t   rsp,
	output frame_cfg_t frame
);

	data_t base_q;
	data_t words_q;
	logic  enable_q;

	logic  hit;
	data_t rdata_d;

	logic  rsp_vld, rsp_hit;
	id_t   rsp_id;
	data_t rsp_data;

	////////////////////////////////////////////////////////////
	// decode and read-back
	////////////////////////////////////////////////////////////
	always_comb begin
		hit     = 1'b1;
		rdata_d = '0;
		case (cmd.addr)
			ADDR_FRAME_BASE:  rdata_d = base_q;
			ADDR_FRAME_WORDS: rdata_d = words_q;
			ADDR_FRAME_EN:    rdata_d = {31'b0, enable_q};
			default:          hit = 1'b0;
		endcase
	end

	always_ff @(posedge external_clk or negedge arst_n) begin
		if (!arst_n) begin
			base_q   <= '0;
			words_q  <= '0;
			enable_q <= 1'b0;
		end else if (cmd.valid && cmd.write) begin
			case (cmd.addr)
				ADDR_FRAME_BASE:  base_q   <= cmd.data;
				ADDR_FRAME_WORDS: words_q  <= cmd.data;
				ADDR_FRAME_EN:    enable_q <= cmd.data[0];   // bit 0 only
				default: ;
			endcase
		end
	end

	assign frame = '{base: base_q, words: words_q, enable: enable_q};

	////////////////////////////////////////////////////////////
	// result stage
	////////////////////////////////////////////////////////////
	always_ff @(posedge external_clk or negedge arst_n) begin
		if (!arst_n) begin
			rsp_vld <= 1'b0;
			rsp_hit <= 1'b0;
		end else begin
			rsp_vld <= cmd.valid;
			rsp_hit <= cmd.valid & hit;
		end
	end

	always_ff @(posedge external_clk) begin
		rsp_id   <= cmd.id;
		rsp_data <= cmd.write ? '0 : rdata_d;
	end

	// frame registers never refuse a write
	assign rsp = '{valid: rsp_vld, hit: rsp_hit, id: rsp_id, resp: RESP_OKAY, rdata: rsp_data};

endmodule

//--- jtag_fifo/jtag_fifo_slave.sv
`timescale 1ns/10ps

module jtag_fifo_slave import bridge_pkg::*; (
	input  logic       external_clk,
	input  logic       arst_n,
	input  cmd_t       cmd,
	output slv_rsp_t   rsp,
	output logic       tck,
	output logic       tms,
	output logic       tdi
);

	data_t                          mem [FIFO_DEPTH];
	logic [$clog2(FIFO_DEPTH)-1:0]  wr_ptr;
	logic [$clog2(FIFO_DEPTH)-1:0]  rd_ptr;
	fifo_cnt_t                      cnt;
	logic                           shift_en;
	logic                           busy;

	logic  hit_stat, hit_data;
	logic  full, empty;
	logic  data_wr, stat_wr;
	logic  push, pop, clear;
	data_t stat_word;

	logic  rsp_vld, rsp_hit;
	id_t   rsp_id;
	resp_t rsp_code;
	data_t rsp_data;

	////////////////////////////////////////////////////////////
	// decode
	////////////////////////////////////////////////////////////
	assign hit_stat = cmd.addr == ADDR_JTAG_STATUS;
	assign hit_data = cmd.addr == ADDR_JTAG_DATA;
	assign data_wr  = cmd.valid & cmd.write & hit_data;
	assign stat_wr  = cmd.valid & cmd.write & hit_stat;

	assign full  = cnt == fifo_cnt_t'(FIFO_DEPTH);
	assign empty = cnt == '0;

	assign push  = data_wr & ~full;   // overflow is dropped, answered with slverr
	assign clear = stat_wr & cmd.data[CTRL_CLEAR];
	assign pop   = shift_en & ~empty & ~busy & ~clear;   // grant to shifter

	always_comb begin
		stat_word = '0;
		stat_word[STAT_CNT_LSB +: $bits(fifo_cnt_t)] = cnt;
		stat_word[STAT_SHIFT_EN] = shift_en;
		stat_word[STAT_EMPTY]    = empty;
		stat_word[STAT_FULL]     = full;
		stat_word[STAT_BUSY]     = busy;
	end

	////////////////////////////////////////////////////////////
	// fifo
	////////////////////////////////////////////////////////////
	always_ff @(posedge external_clk) begin
		if (push)
			mem[wr_ptr] <= cmd.data;
	end

	always_ff @(posedge external_clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			cnt      <= '0;
			shift_en <= 1'b0;
		end else begin
			if (clear) begin
				wr_ptr <= '0;
				rd_ptr <= '0;
				cnt    <= '0;
			end else begin
				if (push)
					wr_ptr <= wr_ptr + 1'b1;
				if (pop)
					rd_ptr <= rd_ptr + 1'b1;
				cnt <= cnt + fifo_cnt_t'(push) - fifo_cnt_t'(pop);
			end
			if (stat_wr)
				shift_en <= cmd.data[CTRL_SHIFT_EN];
		end
	end

	jtag_shifter u_shifter (
		.external_clk (external_clk),
		.arst_n       (arst_n),
		.start        (pop),
		.word         (mem[rd_ptr]),
		.busy         (busy),
		.tck          (tck),
		.tms          (tms),
		.tdi          (tdi)
	);

	////////////////////////////////////////////////////////////
	// result stage
	////////////////////////////////////////////////////////////
	always_ff @(posedge external_clk or negedge arst_n) begin
		if (!arst_n) begin
			rsp_vld <= 1'b0;
			rsp_hit <= 1'b0;
		end else begin
			rsp_vld <= cmd.valid;
			rsp_hit <= cmd.valid & (hit_stat | hit_data);
		end
	end

	always_ff @(posedge external_clk) begin
		rsp_id   <= cmd.id;
		rsp_code <= (data_wr & full) ? RESP_SLVERR : RESP_OKAY;
		rsp_data <= (!cmd.write && hit_stat) ? stat_word : '0;   // data port reads 0
	end

	assign rsp = '{valid: rsp_vld, hit: rsp_hit, id: rsp_id, resp: rsp_code, rdata: rsp_data};

	// an overflowing write leaves the fifo as it was apart from a pop
	a_no_push_full: assert property (@(posedge external_clk) disable iff (!arst_n)
		(data_wr && full) |=> (wr_ptr == $past(wr_ptr)) && (cnt <= $past(cnt)));

	// count tracks the pointers so a clear racing a pop cannot corrupt it
	a_cnt_ptrs: assert property (@(posedge external_clk) disable iff (!arst_n)
		(cnt <= fifo_cnt_t'(FIFO_DEPTH)) &&
		(cnt[$clog2(FIFO_DEPTH)-1:0] == wr_ptr - rd_ptr));

endmodule

//--- jtag_fifo/jtag_shifter.sv
`timescale 1ns/10ps

module jtag_shifter import bridge_pkg::*; (
	input  logic  external_clk,
	input  logic  arst_n,
	input  logic  start,
	input  data_t word,
	output logic  busy,
	output logic  tck,
	output logic  tms,
	output logic  tdi
);

	shift_state_t state;
	data_t        sreg;      // lsb goes out first
	logic [4:0]   bit_cnt;

	always_ff @(posedge external_clk or negedge arst_n) begin
		if (!arst_n) begin
			state   <= S_IDLE;
			bit_cnt <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (start) begin
						bit_cnt <= '0;
						state   <= S_LOW;
					end
				end
				S_LOW: state <= S_HIGH;
				S_HIGH: begin
					if (bit_cnt == 5'd31) begin
						state <= S_IDLE;
					end else begin
						bit_cnt <= bit_cnt + 1'b1;
						state   <= S_LOW;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// loaded on start, shifted after each high phase
	always_ff @(posedge external_clk) begin
		if (state == S_IDLE && start)
			sreg <= word;
		else if (state == S_HIGH)
			sreg <= sreg >> 1;
	end

	assign busy = state != S_IDLE;
	assign tck  = state == S_HIGH;
	assign tms  = busy & (bit_cnt == 5'd31);   // marks the last bit
	assign tdi  = busy & sreg[0];

	a_start_idle: assert property (@(posedge external_clk) disable iff (!arst_n)
		start |-> !busy);

endmodule

//--- common/bridge_pkg.sv
package bridge_pkg;

	////////////////////////////////////////////////////////////
	// basic widths
	////////////////////////////////////////////////////////////
	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [2:0]  id_t;
	typedef logic [1:0]  resp_t;
	typedef logic [3:0]  fifo_cnt_t;   // 0..8 words

	localparam resp_t RESP_OKAY   = 2'b00;
	localparam resp_t RESP_SLVERR = 2'b10;   // unmapped address or fifo overflow

	// register map
	localparam addr_t ADDR_JTAG_STATUS = 32'h1000_0000;
	localparam addr_t ADDR_JTAG_DATA   = 32'h1000_0002;
	localparam addr_t ADDR_FRAME_BASE  = 32'h7000_0012;
	localparam addr_t ADDR_FRAME_WORDS = 32'h7000_0013;
	localparam addr_t ADDR_FRAME_EN    = 32'h7000_0014;

	localparam int FIFO_DEPTH = 8;

	// jtag status word layout
	localparam int STAT_CNT_LSB  = 0;   // count in 3:0
	localparam int STAT_SHIFT_EN = 4;
	localparam int STAT_EMPTY    = 8;
	localparam int STAT_FULL     = 9;
	localparam int STAT_BUSY     = 16;

	// control bits of a status write
	localparam int CTRL_CLEAR    = 0;
	localparam int CTRL_SHIFT_EN = 1;

	typedef enum logic [1:0] {S_IDLE, S_LOW, S_HIGH} shift_state_t;

	////////////////////////////////////////////////////////////
	// bus structs
	////////////////////////////////////////////////////////////
	typedef struct packed {
		logic  valid;
		logic  write;
		id_t   id;
		addr_t addr;
		data_t data;
	} cmd_t;

	typedef struct packed {
		logic  valid;
		logic  hit;     // this slave owns the address
		id_t   id;
		resp_t resp;
		data_t rdata;
	} slv_rsp_t;

	typedef struct packed {
		logic  valid;
		id_t   id;
		resp_t resp;
		data_t rdata;
	} bus_rsp_t;

	typedef struct packed {
		data_t base;
		data_t words;
		logic  enable;
	} frame_cfg_t;

endpackage
